// ==== hdl/LsuPkg.sv ====
package LsuPkg;

    typedef logic [31:0] VirtAddr;
    typedef logic [31:0] PhysAddr;
    typedef logic [19:0] Vpn;
    typedef logic [19:0] Ppn;
    typedef logic [6:0] SqNum;
    typedef logic [6:0] TagDst;

    // Legal RAM window
    localparam PhysAddr RamBase = 32'h8000_0000;
    localparam PhysAddr RamSize = 32'h0100_0000;

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } LsuOpcode;

    typedef enum logic [2:0] {
        NONE,
        LD_MA,
        ST_MA,
        LD_AF,
        ST_AF,
        LD_PF,
        ST_PF
    } FaultFlags;

    typedef enum logic {
        USER,
        SUPERVISOR
    } Privilege;

    typedef struct packed {
        logic valid;
        LsuOpcode opcode;
        logic [31:0] srcA;
        logic [31:0] srcB;
        TagDst tagDst;
        SqNum sqN;
    } ExUop;

    typedef struct packed {
        logic valid;
        VirtAddr addr;
        logic [1:0] size;
        logic signExtend;
        logic isLoad;
        logic isStore;
        logic [3:0] wmask;
        TagDst tagDst;
        SqNum sqN;
    } AguUop;

    typedef struct packed {
        logic valid;
        TagDst tagDst;
        SqNum sqN;
        FaultFlags flags;
    } ResUop;

    typedef struct packed {
        logic taken;
        SqNum sqN;
    } BranchProv;

    typedef struct packed {
        logic sv32en;
        Privilege priv;
        logic supervUserMemory;
        Ppn rootPpn;
    } VmemState;

    typedef struct packed {
        logic valid;
        Vpn vpn;
    } TlbReq;

    typedef struct packed {
        logic hit;
        Ppn ppn;
        logic [2:0] rwx;
        logic user;
        logic pageFault;
    } TlbRes;

    typedef struct packed {
        logic valid;
        Vpn vpn;
        Ppn rootPpn;
    } WalkReq;

    typedef struct packed {
        logic valid;
        Vpn vpn;
        Ppn ppn;
        logic [2:0] rwx;
        logic user;
        logic pageFault;
    } WalkRes;

    // True when sqN a is younger than sqN b
    function automatic logic isYounger(input SqNum a, input SqNum b);
        return $signed(a - b) > 0;
    endfunction

endpackage

// ==== hdl/AddrGenUnit.sv ====
`timescale 1ns/1ps

module AddrGenUnit #(
    parameter int MissQueueDepth = 4
) (
    input  logic clk,
    input  logic rst,
    input  LsuPkg::ExUop exUop,
    input  LsuPkg::BranchProv branch,
    input  LsuPkg::VmemState vmem,
    input  LsuPkg::TlbRes tlbRes,
    input  LsuPkg::AguUop mqUop,
    input  LsuPkg::FaultFlags mqFault,
    input  logic [$clog2(MissQueueDepth):0] mqFree,
    input  logic walkBusy,
    input  LsuPkg::WalkRes walkRes,
    output logic stall,
    output LsuPkg::TlbReq tlbReq,
    output logic mqEnqueue,
    output logic mqDequeue,
    output LsuPkg::AguUop mqInUop,
    output LsuPkg::WalkReq walkReq,
    output LsuPkg::AguUop aguOp,
    output LsuPkg::ResUop resUop
);

    function automatic logic isPermFault(input logic [2:0] rwx, input logic user,
                                         input logic isStore, input LsuPkg::VmemState vm);
        logic fault;
        fault = (!isStore && !rwx[2]) || (isStore && !rwx[1]);
        if (vm.priv == LsuPkg::USER && !user) begin
            fault = 1'b1;
        end
        if (vm.priv == LsuPkg::SUPERVISOR && user && !vm.supervUserMemory) begin
            fault = 1'b1;
        end
        return fault;
    endfunction

    LsuPkg::VirtAddr newAddr;
    LsuPkg::PhysAddr physAddr;
    LsuPkg::AguUop decUop;
    LsuPkg::AguUop issUop;
    LsuPkg::FaultFlags issFault;
    LsuPkg::FaultFlags flags;
    LsuPkg::AguUop nextAgu;
    LsuPkg::ResUop nextRes;
    logic issKeep;
    logic misaligned;
    logic tlbMiss;
    logic walkActive;

    assign stall = (mqFree == 0);
    assign newAddr = exUop.srcA + exUop.srcB;

    always_comb begin
        decUop = '0;
        decUop.valid = exUop.valid && !stall;
        decUop.addr = newAddr;
        decUop.tagDst = exUop.tagDst;
        decUop.sqN = exUop.sqN;
        decUop.isLoad = 1'b1;
        case (exUop.opcode)
            LsuPkg::LB: begin
                decUop.size = 2'd0;
                decUop.signExtend = 1'b1;
            end
            LsuPkg::LH: begin
                decUop.size = 2'd1;
                decUop.signExtend = 1'b1;
            end
            LsuPkg::LW: decUop.size = 2'd2;
            LsuPkg::LBU: decUop.size = 2'd0;
            LsuPkg::LHU: decUop.size = 2'd1;
            default: begin
                decUop.isLoad = 1'b0;
                decUop.isStore = 1'b1;
                decUop.size = 2'd2;
                decUop.wmask = 4'b1111;
                if (exUop.opcode == LsuPkg::SB) begin
                    decUop.size = 2'd0;
                    decUop.wmask = 4'b0001 << newAddr[1:0];
                end else if (exUop.opcode == LsuPkg::SH) begin
                    decUop.size = 2'd1;
                    decUop.wmask = newAddr[1] ? 4'b1100 : 4'b0011;
                end
            end
        endcase
    end

    // New input wins, the queue replays only in otherwise idle cycles
    always_comb begin
        issUop = decUop;
        issFault = LsuPkg::NONE;
        mqDequeue = 1'b0;
        if (!decUop.valid && mqUop.valid) begin
            issUop = mqUop;
            issFault = mqFault;
            mqDequeue = 1'b1;
        end
    end

    assign issKeep = issUop.valid && !(branch.taken && LsuPkg::isYounger(issUop.sqN, branch.sqN));
    assign misaligned = (issUop.size == 2'd1 && issUop.addr[0])
        || (issUop.size == 2'd2 && issUop.addr[1:0] != 2'b00);

    assign tlbReq.valid = issUop.valid && vmem.sv32en;
    assign tlbReq.vpn = issUop.addr[31:12];

    assign physAddr = vmem.sv32en ? {tlbRes.ppn, issUop.addr[11:0]} : issUop.addr;
    assign tlbMiss = vmem.sv32en && !tlbRes.hit && !misaligned && issFault == LsuPkg::NONE;

    always_comb begin
        flags = LsuPkg::NONE;
        if (issFault != LsuPkg::NONE) begin
            flags = issFault;
        end else if (misaligned) begin
            flags = issUop.isStore ? LsuPkg::ST_MA : LsuPkg::LD_MA;
        end else if (vmem.sv32en && tlbRes.hit && (tlbRes.pageFault
                     || isPermFault(tlbRes.rwx, tlbRes.user, issUop.isStore, vmem))) begin
            flags = issUop.isStore ? LsuPkg::ST_PF : LsuPkg::LD_PF;
        end else if (!tlbMiss && (physAddr - LsuPkg::RamBase) >= LsuPkg::RamSize) begin
            flags = issUop.isStore ? LsuPkg::ST_AF : LsuPkg::LD_AF;
        end
    end

    always_comb begin
        nextAgu = issUop;
        nextAgu.addr = physAddr;
        nextAgu.valid = issKeep && !tlbMiss && flags == LsuPkg::NONE;
        nextRes.valid = issKeep && !tlbMiss && (issUop.isStore || flags != LsuPkg::NONE);
        nextRes.tagDst = issUop.tagDst;
        nextRes.sqN = issUop.sqN;
        nextRes.flags = flags;
    end

    assign mqEnqueue = issKeep && tlbMiss;
    assign mqInUop = issUop;

    // One walk at a time, later misses wait in the queue
    always_ff @(posedge clk) begin
        if (rst) begin
            walkActive <= 1'b0;
            walkReq.valid <= 1'b0;
        end else begin
            if (walkReq.valid && walkBusy) begin
                walkReq.valid <= 1'b0;
            end
            if (walkRes.valid) begin
                walkActive <= 1'b0;
            end else if (mqEnqueue && !walkActive) begin
                walkActive <= 1'b1;
                walkReq.valid <= 1'b1;
                walkReq.vpn <= issUop.addr[31:12];
                walkReq.rootPpn <= vmem.rootPpn;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aguOp.valid <= 1'b0;
            resUop.valid <= 1'b0;
        end else begin
            aguOp <= nextAgu;
            resUop <= nextRes;
        end
    end

    // A uop that went out fault-free never comes back with a fault
    aguOpNotFaulted: assert property (@(posedge clk) disable iff (rst)
        aguOp.valid |=> !(resUop.valid && resUop.flags != LsuPkg::NONE
                          && resUop.sqN == $past(aguOp.sqN)));

    walkReqHeld: assert property (@(posedge clk) disable iff (rst)
        walkReq.valid && !walkBusy
        |=> walkReq.valid && $stable(walkReq.vpn) && $stable(walkReq.rootPpn));

endmodule

// ==== hdl/TlbMissQueue.sv ====
`timescale 1ns/1ps

module TlbMissQueue #(
    parameter int MissQueueDepth = 4
) (
    input  logic clk,
    input  logic rst,
    input  LsuPkg::BranchProv branch,
    input  logic enqueue,
    input  LsuPkg::AguUop inUop,
    input  logic dequeue,
    input  LsuPkg::WalkRes walkRes,
    output logic [$clog2(MissQueueDepth):0] free,
    output LsuPkg::AguUop outUop,
    output LsuPkg::FaultFlags outFault
);

    localparam int IdxW = (MissQueueDepth > 1) ? $clog2(MissQueueDepth) : 1;
    localparam int CntW = $clog2(MissQueueDepth) + 1;

    // Fault a parked uop inherits from a finished walk
    function automatic LsuPkg::FaultFlags walkFault(input LsuPkg::AguUop u,
                                                    input LsuPkg::WalkRes w);
        if (w.vpn != u.addr[31:12] || !w.pageFault) begin
            return LsuPkg::NONE;
        end
        return u.isStore ? LsuPkg::ST_PF : LsuPkg::LD_PF;
    endfunction

    LsuPkg::AguUop slotUop [MissQueueDepth];
    LsuPkg::FaultFlags slotFault [MissQueueDepth];
    logic [MissQueueDepth-1:0] slotReady;
    logic [IdxW-1:0] sel;
    logic [IdxW-1:0] insIdx;
    logic found;
    logic insFound;
    logic [$clog2(MissQueueDepth):0] count;

    always_comb begin
        found = 1'b0;
        sel = '0;
        insFound = 1'b0;
        insIdx = '0;
        count = '0;
        for (int i = 0; i < MissQueueDepth; i++) begin
            if (slotUop[i].valid && slotReady[i]
                && (!found || LsuPkg::isYounger(slotUop[sel].sqN, slotUop[i].sqN))) begin
                sel = IdxW'(i);
                found = 1'b1;
            end
            if (slotUop[i].valid) begin
                count = count + 1'b1;
            end
        end
        for (int i = 0; i < MissQueueDepth; i++) begin
            if (!insFound && (!slotUop[i].valid || (dequeue && sel == IdxW'(i)))) begin
                insIdx = IdxW'(i);
                insFound = 1'b1;
            end
        end
        outUop = slotUop[sel];
        outUop.valid = found;
        outFault = slotFault[sel];
    end

    assign free = CntW'(MissQueueDepth) - count;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MissQueueDepth; i++) begin
                slotUop[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < MissQueueDepth; i++) begin
                // Other pages retry too and start their own walk
                if (walkRes.valid && slotUop[i].valid && !slotReady[i]) begin
                    slotReady[i] <= 1'b1;
                    slotFault[i] <= walkFault(slotUop[i], walkRes);
                end
                if (branch.taken && LsuPkg::isYounger(slotUop[i].sqN, branch.sqN)) begin
                    slotUop[i].valid <= 1'b0;
                end
            end
            if (dequeue) begin
                slotUop[sel].valid <= 1'b0;
            end
            if (enqueue) begin
                slotUop[insIdx] <= inUop;
                slotReady[insIdx] <= walkRes.valid;
                slotFault[insIdx] <= walkRes.valid ? walkFault(inUop, walkRes) : LsuPkg::NONE;
            end
        end
    end

    // A replayed miss may re-enter a full queue through its own slot
    noOverflow: assert property (@(posedge clk) disable iff (rst)
        enqueue && !dequeue |-> free != 0);

endmodule

// ==== hdl/DataTlb.sv ====
`timescale 1ns/1ps

module DataTlb #(
    parameter int TlbEntries = 8
) (
    input  logic clk,
    input  logic rst,
    input  LsuPkg::TlbReq req,
    input  LsuPkg::WalkRes fill,
    output LsuPkg::TlbRes res
);

    localparam int IdxW = (TlbEntries > 1) ? $clog2(TlbEntries) : 1;

    typedef struct packed {
        LsuPkg::Vpn vpn;
        LsuPkg::Ppn ppn;
        logic [2:0] rwx;
        logic user;
    } TlbEntry;

    TlbEntry entries [TlbEntries];
    logic [TlbEntries-1:0] entValid;
    logic [IdxW-1:0] victim;

    always_comb begin
        res = '0;
        for (int i = 0; i < TlbEntries; i++) begin
            if (req.valid && entValid[i] && entries[i].vpn == req.vpn) begin
                res.hit = 1'b1;
                res.ppn = entries[i].ppn;
                res.rwx = entries[i].rwx;
                res.user = entries[i].user;
            end
        end
        // W without R is a reserved leaf encoding
        res.pageFault = res.hit && res.rwx[1] && !res.rwx[2];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
            victim <= '0;
        end else if (fill.valid && !fill.pageFault) begin
            entValid[victim] <= 1'b1;
            entries[victim].vpn <= fill.vpn;
            entries[victim].ppn <= fill.ppn;
            entries[victim].rwx <= fill.rwx;
            entries[victim].user <= fill.user;
            if (victim == IdxW'(TlbEntries - 1)) begin
                victim <= '0;
            end else begin
                victim <= victim + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/PageWalker.sv ====
`timescale 1ns/1ps

module PageWalker (
    input  logic clk,
    input  logic rst,
    input  LsuPkg::WalkReq req,
    input  logic pready,
    input  logic [31:0] prdata,
    output logic busy,
    output LsuPkg::WalkRes res,
    output logic psel,
    output logic penable,
    output logic pwrite,
    output LsuPkg::PhysAddr paddr
);

    typedef enum logic [2:0] {
        Idle,
        L1Setup,
        L1Access,
        L0Setup,
        L0Access,
        Done
    } WalkState;

    WalkState state;
    LsuPkg::Vpn vpnQ;
    LsuPkg::Ppn ppnQ;
    logic [2:0] rwxQ;
    logic userQ;
    logic faultQ;
    logic pteValid;
    logic pteLeaf;

    // PTE bits V=0 R=1 W=2 X=3 U=4
    assign pteValid = prdata[0];
    assign pteLeaf = prdata[1] || prdata[2] || prdata[3];

    assign busy = (state != Idle);
    assign psel = (state == L1Setup) || (state == L1Access)
        || (state == L0Setup) || (state == L0Access);
    assign penable = (state == L1Access) || (state == L0Access);
    assign pwrite = 1'b0;

    assign res.valid = (state == Done);
    assign res.vpn = vpnQ;
    assign res.ppn = ppnQ;
    assign res.rwx = rwxQ;
    assign res.user = userQ;
    assign res.pageFault = faultQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: begin
                    if (req.valid) begin
                        vpnQ <= req.vpn;
                        faultQ <= 1'b0;
                        paddr <= {req.rootPpn, req.vpn[19:10], 2'b00};
                        state <= L1Setup;
                    end
                end
                L1Setup: state <= L1Access;
                L1Access: begin
                    if (pready) begin
                        // No superpages, so a level-1 leaf faults as well
                        if (!pteValid || pteLeaf) begin
                            faultQ <= 1'b1;
                            state <= Done;
                        end else begin
                            paddr <= {prdata[29:10], vpnQ[9:0], 2'b00};
                            state <= L0Setup;
                        end
                    end
                end
                L0Setup: state <= L0Access;
                L0Access: begin
                    if (pready) begin
                        faultQ <= !pteValid || !pteLeaf;
                        ppnQ <= prdata[29:10];
                        rwxQ <= {prdata[1], prdata[2], prdata[3]};
                        userQ <= prdata[4];
                        state <= Done;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    apbSetupFirst: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> $past(psel && !penable));

endmodule

// ==== hdl/LsuAddrStage.sv ====
`timescale 1ns/1ps

module LsuAddrStage #(
    parameter int MissQueueDepth = 4,
    parameter int TlbEntries = 8
) (
    input  logic clk,
    input  logic rst,
    input  LsuPkg::ExUop exUop,
    input  LsuPkg::BranchProv branch,
    input  LsuPkg::VmemState vmem,
    input  logic pready,
    input  logic [31:0] prdata,
    output logic stall,
    output LsuPkg::AguUop aguOp,
    output LsuPkg::ResUop resUop,
    output logic psel,
    output logic penable,
    output logic pwrite,
    output LsuPkg::PhysAddr paddr
);

    LsuPkg::TlbReq tlbReq;
    LsuPkg::TlbRes tlbRes;
    LsuPkg::AguUop mqUop;
    LsuPkg::AguUop mqInUop;
    LsuPkg::FaultFlags mqFault;
    logic [$clog2(MissQueueDepth):0] mqFree;
    logic mqEnqueue;
    logic mqDequeue;
    LsuPkg::WalkReq walkReq;
    LsuPkg::WalkRes walkRes;
    logic walkBusy;

    AddrGenUnit #(
        .MissQueueDepth(MissQueueDepth)
    ) agu (
        .clk(clk),
        .rst(rst),
        .exUop(exUop),
        .branch(branch),
        .vmem(vmem),
        .tlbRes(tlbRes),
        .mqUop(mqUop),
        .mqFault(mqFault),
        .mqFree(mqFree),
        .walkBusy(walkBusy),
        .walkRes(walkRes),
        .stall(stall),
        .tlbReq(tlbReq),
        .mqEnqueue(mqEnqueue),
        .mqDequeue(mqDequeue),
        .mqInUop(mqInUop),
        .walkReq(walkReq),
        .aguOp(aguOp),
        .resUop(resUop)
    );

    TlbMissQueue #(
        .MissQueueDepth(MissQueueDepth)
    ) missQueue (
        .clk(clk),
        .rst(rst),
        .branch(branch),
        .enqueue(mqEnqueue),
        .inUop(mqInUop),
        .dequeue(mqDequeue),
        .walkRes(walkRes),
        .free(mqFree),
        .outUop(mqUop),
        .outFault(mqFault)
    );

    DataTlb #(
        .TlbEntries(TlbEntries)
    ) dtlb (
        .clk(clk),
        .rst(rst),
        .req(tlbReq),
        .fill(walkRes),
        .res(tlbRes)
    );

    PageWalker walker (
        .clk(clk),
        .rst(rst),
        .req(walkReq),
        .pready(pready),
        .prdata(prdata),
        .busy(walkBusy),
        .res(walkRes),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr)
    );

endmodule

// ==== tests/PageTableMem.sv ====
`timescale 1ns/1ps

module PageTableMem (
    input  logic clk,
    input  logic rst,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [31:0] paddr,
    input  logic [1:0] waitSel,
    output logic pready,
    output logic [31:0] prdata
);

    logic [31:0] words [logic [31:0]];
    logic [1:0] waitCnt;

    // Root table at 0x8001_0000, leaf tables at 0x8001_1000 and 0x8001_2000
    initial begin
        words[32'h8001_0004] = 32'h2000_4401;
        words[32'h8001_0008] = 32'h2000_4801;
        // User RW, supervisor RW, user read-only, slot 3 left unmapped
        words[32'h8001_1000] = 32'h2004_0017;
        words[32'h8001_1004] = 32'h2004_0407;
        words[32'h8001_1008] = 32'h2004_0813;
        for (int i = 0; i < 4; i++) begin
            words[32'h8001_2000 + 4 * i] = ((32'h80200 + i) << 10) | 32'h1f;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            waitCnt <= '0;
        end else if (psel && !penable) begin
            waitCnt <= waitSel;
        end else if (psel && penable && waitCnt != 0) begin
            waitCnt <= waitCnt - 1'b1;
        end
    end

    assign pready = psel && penable && waitCnt == 0;

    // Tables are read-only, a write returns no data
    always_comb begin
        prdata = '0;
        if (!pwrite && words.exists(paddr)) begin
            prdata = words[paddr];
        end
    end

endmodule

// ==== tests/LsuAddrStageTb.sv ====
`timescale 1ns/1ps

module LsuAddrStageTb;

    localparam int NumTests = 6;

    logic clk;
    logic rst;
    LsuPkg::ExUop exUop;
    LsuPkg::BranchProv branch;
    LsuPkg::VmemState vmem;
    logic pready;
    logic [31:0] prdata;
    logic stall;
    LsuPkg::AguUop aguOp;
    LsuPkg::ResUop resUop;
    logic psel;
    logic penable;
    logic pwrite;
    LsuPkg::PhysAddr paddr;
    logic [1:0] waitSel;

    logic [31:0] lfsr = 32'h5675_688b;
    int errors = 0;
    int cycle = 0;
    logic stallSeen = 1'b0;
    LsuPkg::SqNum nextSq = '0;

    // Scoreboard keyed by sqN
    LsuPkg::AguUop expAgu [128];
    LsuPkg::ResUop expRes [128];
    logic needAgu [128];
    logic needRes [128];
    logic fastQ [128];
    int issueCnt [128];

    LsuAddrStage #(
        .MissQueueDepth(4),
        .TlbEntries(8)
    ) UUT (
        .clk(clk), .rst(rst), .exUop(exUop), .branch(branch), .vmem(vmem),
        .pready(pready), .prdata(prdata), .stall(stall), .aguOp(aguOp),
        .resUop(resUop), .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr)
    );

    PageTableMem ptMem (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .waitSel(waitSel), .pready(pready), .prdata(prdata)
    );

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // Copy of the page table contents, rwx ordered as R W X
    task automatic pageLookup(input logic [19:0] vpn, output logic mapped,
                              output logic [19:0] ppn, output logic [2:0] rwx, output logic user);
        mapped = 1'b1;
        ppn = '0;
        rwx = 3'b000;
        user = 1'b1;
        case (vpn)
            20'h00400: {ppn, rwx} = {20'h80100, 3'b110};
            20'h00401: {ppn, rwx, user} = {20'h80101, 3'b110, 1'b0};
            20'h00402: {ppn, rwx} = {20'h80102, 3'b100};
            20'h00800, 20'h00801, 20'h00802, 20'h00803: {ppn, rwx} = {20'h80200 + vpn[1:0], 3'b111};
            default: mapped = 1'b0;
        endcase
    endtask

    task automatic setExpect(input LsuPkg::SqNum sq, input LsuPkg::TagDst tag,
                             input LsuPkg::LsuOpcode op, input logic [31:0] va, input logic fast);
        LsuPkg::AguUop e;
        LsuPkg::FaultFlags f;
        logic ma;
        logic mapped;
        logic [19:0] ppn;
        logic [2:0] rwx;
        logic user;
        logic pf;
        logic [31:0] pa;
        e = '0;
        e.valid = 1'b1;
        e.tagDst = tag;
        e.sqN = sq;
        e.isStore = (op == LsuPkg::SB || op == LsuPkg::SH || op == LsuPkg::SW);
        e.isLoad = !e.isStore;
        e.signExtend = (op == LsuPkg::LB || op == LsuPkg::LH);
        case (op)
            LsuPkg::LB, LsuPkg::LBU, LsuPkg::SB: e.size = 2'd0;
            LsuPkg::LH, LsuPkg::LHU, LsuPkg::SH: e.size = 2'd1;
            default: e.size = 2'd2;
        endcase
        if (op == LsuPkg::SB) begin
            e.wmask = 4'b0001 << va[1:0];
        end else if (op == LsuPkg::SH) begin
            e.wmask = va[1] ? 4'b1100 : 4'b0011;
        end else if (op == LsuPkg::SW) begin
            e.wmask = 4'b1111;
        end
        ma = (e.size == 2'd1 && va[0]) || (e.size == 2'd2 && va[1:0] != 2'b00);
        pa = va;
        pf = 1'b0;
        if (vmem.sv32en) begin
            pageLookup(va[31:12], mapped, ppn, rwx, user);
            pa = {ppn, va[11:0]};
            pf = !mapped || (e.isStore ? !rwx[1] : !rwx[2])
                || (vmem.priv == LsuPkg::USER && !user)
                || (vmem.priv == LsuPkg::SUPERVISOR && user && !vmem.supervUserMemory);
        end
        if (ma) begin
            f = e.isStore ? LsuPkg::ST_MA : LsuPkg::LD_MA;
        end else if (pf) begin
            f = e.isStore ? LsuPkg::ST_PF : LsuPkg::LD_PF;
        end else if (pa < 32'h8000_0000 || pa >= 32'h8100_0000) begin
            f = e.isStore ? LsuPkg::ST_AF : LsuPkg::LD_AF;
        end else begin
            f = LsuPkg::NONE;
        end
        e.addr = pa;
        expAgu[sq] = e;
        expRes[sq] = {1'b1, tag, sq, f};
        needAgu[sq] = (f == LsuPkg::NONE);
        needRes[sq] = e.isStore || f != LsuPkg::NONE;
        fastQ[sq] = fast;
    endtask

    // Called 2 ns after a rising edge, returns at the same point after acceptance
    task automatic sendUop(input LsuPkg::LsuOpcode op, input logic [31:0] a,
                           input logic [31:0] b, input logic fast);
        LsuPkg::SqNum sq;
        LsuPkg::TagDst tag;
        sq = nextSq;
        nextSq = nextSq + 1'b1;
        tag = LsuPkg::TagDst'(randBits(7));
        setExpect(sq, tag, op, a + b, fast);
        exUop = {1'b1, op, a, b, tag, sq};
        forever begin
            @(negedge clk);
            if (!stall) begin
                break;
            end
            stallSeen = 1'b1;
        end
        issueCnt[sq] = cycle;
        @(posedge clk);
        #2;
        exUop.valid = 1'b0;
    endtask

    function automatic int outstanding();
        int n;
        n = 0;
        for (int i = 0; i < 128; i++) begin
            if (needAgu[i] || needRes[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic waitIdle();
        while (outstanding() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        #2;
    endtask

    function automatic logic aguMatches(input LsuPkg::AguUop u);
        return needAgu[u.sqN] && u == expAgu[u.sqN]
            && (!fastQ[u.sqN] || cycle == issueCnt[u.sqN] + 1);
    endfunction

    function automatic logic resMatches(input LsuPkg::ResUop u);
        return needRes[u.sqN] && u == expRes[u.sqN]
            && (!fastQ[u.sqN] || cycle == issueCnt[u.sqN] + 1);
    endfunction

    aguChecked: assert property (@(negedge clk) disable iff (rst)
        aguOp.valid |-> aguMatches(aguOp))
    else begin
        errors++;
        $display("** Error at %0t: unexpected aguOp for sqN %0d", $time, aguOp.sqN);
    end

    resChecked: assert property (@(negedge clk) disable iff (rst)
        resUop.valid |-> resMatches(resUop))
    else begin
        errors++;
        $display("** Error at %0t: unexpected resUop for sqN %0d", $time, resUop.sqN);
    end

    // The walker only ever reads page tables
    apbReadOnly: assert property (@(negedge clk) disable iff (rst)
        psel |-> !pwrite)
    else begin
        errors++;
        $display("** Error at %0t: pwrite high during an APB transfer", $time);
    end

    // Retire what the previous cycle delivered
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!rst && aguOp.valid) begin
            needAgu[aguOp.sqN] <= 1'b0;
        end
        if (!rst && resUop.valid) begin
            needRes[resUop.sqN] <= 1'b0;
        end
    end

    always @(negedge clk) begin
        waitSel = 2'(randBits(2));
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (NumTests * 200) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", NumTests * 200);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        LsuPkg::SqNum branchSq;
        logic signed [6:0] age;
        for (int i = 0; i < 128; i++) begin
            needAgu[i] = 1'b0;
            needRes[i] = 1'b0;
        end
        rst = 1'b1;
        exUop = '0;
        branch = '0;
        vmem = '0;
        waitSel = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // Bare mode with random operands
        for (int i = 0; i < 24; i++) begin
            sendUop(LsuPkg::LsuOpcode'(randBits(3)), 32'h8000_0000 | randBits(23), randBits(8), 1'b1);
        end
        // Misalignment and access faults
        sendUop(LsuPkg::LH, 32'h8000_0001, 32'h0, 1'b1);
        sendUop(LsuPkg::SW, 32'h8000_0000, 32'h2, 1'b1);
        sendUop(LsuPkg::LW, 32'h9000_0000, 32'h0, 1'b1);
        sendUop(LsuPkg::SB, 32'h0000_0010, 32'h0, 1'b1);
        waitIdle();

        // Miss, walk and replay, then a hit
        vmem = {1'b1, LsuPkg::USER, 1'b0, 20'h80010};
        sendUop(LsuPkg::LW, 32'h0040_0000, 32'h10, 1'b0);
        waitIdle();
        sendUop(LsuPkg::SH, 32'h0040_0020, 32'h2, 1'b1);
        waitIdle();

        // Permission and page faults
        sendUop(LsuPkg::SW, 32'h0040_2000, 32'h4, 1'b0);
        sendUop(LsuPkg::LW, 32'h0040_1000, 32'h8, 1'b0);
        sendUop(LsuPkg::LW, 32'h0040_3000, 32'h0, 1'b0);
        sendUop(LsuPkg::LW, 32'h00c0_0000, 32'h0, 1'b0);
        waitIdle();
        vmem.priv = LsuPkg::SUPERVISOR;
        sendUop(LsuPkg::LW, 32'h0040_0000, 32'h8, 1'b1);
        waitIdle();
        vmem.supervUserMemory = 1'b1;
        sendUop(LsuPkg::LW, 32'h0040_0000, 32'h8, 1'b1);
        sendUop(LsuPkg::SW, 32'h0040_1000, 32'hc, 1'b1);
        waitIdle();

        // Branch flush at the input and in the miss queue
        vmem = {1'b1, LsuPkg::USER, 1'b0, 20'h80010};
        branchSq = nextSq;
        sendUop(LsuPkg::LW, 32'h0080_0000, 32'h0, 1'b0);
        sendUop(LsuPkg::LW, 32'h0080_1000, 32'h4, 1'b0);
        branch = {1'b1, branchSq};
        sendUop(LsuPkg::SW, 32'h0040_0000, 32'h0, 1'b1);
        branch = '0;
        for (int i = 0; i < 128; i++) begin
            age = 7'(i) - branchSq;
            if (age > 0) begin
                needAgu[i] = 1'b0;
                needRes[i] = 1'b0;
            end
        end
        waitIdle();

        // Enough misses to fill the queue
        for (int i = 0; i < 6; i++) begin
            sendUop(LsuPkg::LW, 32'h0080_1000 + (i % 3) * 32'h1000, 4 * i, 1'b0);
        end
        waitIdle();
        if (!stallSeen) begin
            errors++;
            $display("stall never rose while the miss queue was full");
        end

        for (int i = 0; i < 128; i++) begin
            if (needAgu[i] || needRes[i]) begin
                errors++;
                $display("Uop with sqN %0d never produced its expected output", i);
            end
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== lsu.f ====
hdl/LsuPkg.sv
hdl/AddrGenUnit.sv
hdl/TlbMissQueue.sv
hdl/DataTlb.sv
hdl/PageWalker.sv
hdl/LsuAddrStage.sv
tests/PageTableMem.sv
tests/LsuAddrStageTb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - hdl/LsuPkg.sv
  - hdl/AddrGenUnit.sv
  - hdl/TlbMissQueue.sv
  - hdl/DataTlb.sv
  - hdl/PageWalker.sv
  - hdl/LsuAddrStage.sv
  - target: test
    files:
      - tests/PageTableMem.sv
      - tests/LsuAddrStageTb.sv
